// ==== src/cpu_config.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths, APB offsets and reset values of the 8-bit core.
// Offsets assume an 8-bit paddr. Only bits 15:0 of an instruction write count.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define CPU_DATA_W      8           // A, X, Y and P width
`define APB_DATA_W      32
`define APB_ADDR_W      8

`define ADDR_INSTR      8'h00       // Opcode in 7:0, operand in 15:8
`define ADDR_A          8'h04
`define ADDR_X          8'h08
`define ADDR_Y          8'h0C
`define ADDR_P          8'h10

`define P_RESET         8'h34       // Bits 5, 4 and 2 set
`define TIMEOUT_PER_TXN 4           // Cycle budget per pattern line
`define TIMEOUT_MARGIN  50

`endif

// ==== src/cpu_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the core. Only immediate, accumulator and implied
// forms exist, so operations carry no addressing mode.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cpu_pkg;

    typedef enum logic [5:0] {
        OP_NONE,
        OP_LDA,
        OP_LDX,
        OP_LDY,
        OP_ADC,
        OP_SBC,
        OP_AND,
        OP_ORA,
        OP_EOR,
        OP_CMP,
        OP_CPX,
        OP_CPY,
        OP_ASL,
        OP_LSR,
        OP_ROL,
        OP_ROR,
        OP_INC,
        OP_DEC,
        OP_INX,
        OP_INY,
        OP_DEX,
        OP_DEY,
        OP_TAX,
        OP_TAY,
        OP_TXA,
        OP_TYA,
        OP_CLC,
        OP_SEC,
        OP_CLV,
        OP_NOP
    } op_e;

    typedef enum logic [1:0] {
        DST_NONE,
        DST_A,
        DST_X,
        DST_Y
    } dst_e;

    typedef enum logic [1:0] {
        IDLE,
        DECODE,
        EXEC
    } state_e;

    // Status register bit positions
    localparam int FLAG_N = 7;
    localparam int FLAG_V = 6;
    localparam int FLAG_Z = 1;
    localparam int FLAG_C = 0;

endpackage

// ==== src/opcode_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 65C02 opcode table for the kept subset. Any other code is illegal.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "cpu_config.svh"

module opcode_decoder (
    input  logic [`CPU_DATA_W-1:0] opcode,
    output cpu_pkg::op_e           op,
    output cpu_pkg::dst_e          dst,
    output logic                   legal
);

    always_comb begin
        case (opcode)
            8'hA9:   op = cpu_pkg::OP_LDA;      // Immediate forms
            8'hA2:   op = cpu_pkg::OP_LDX;
            8'hA0:   op = cpu_pkg::OP_LDY;
            8'h69:   op = cpu_pkg::OP_ADC;
            8'hE9:   op = cpu_pkg::OP_SBC;
            8'h29:   op = cpu_pkg::OP_AND;
            8'h09:   op = cpu_pkg::OP_ORA;
            8'h49:   op = cpu_pkg::OP_EOR;
            8'hC9:   op = cpu_pkg::OP_CMP;
            8'hE0:   op = cpu_pkg::OP_CPX;
            8'hC0:   op = cpu_pkg::OP_CPY;
            8'h0A:   op = cpu_pkg::OP_ASL;      // Accumulator forms
            8'h4A:   op = cpu_pkg::OP_LSR;
            8'h2A:   op = cpu_pkg::OP_ROL;
            8'h6A:   op = cpu_pkg::OP_ROR;
            8'h1A:   op = cpu_pkg::OP_INC;
            8'h3A:   op = cpu_pkg::OP_DEC;
            8'hE8:   op = cpu_pkg::OP_INX;      // Implied forms
            8'hC8:   op = cpu_pkg::OP_INY;
            8'hCA:   op = cpu_pkg::OP_DEX;
            8'h88:   op = cpu_pkg::OP_DEY;
            8'hAA:   op = cpu_pkg::OP_TAX;
            8'hA8:   op = cpu_pkg::OP_TAY;
            8'h8A:   op = cpu_pkg::OP_TXA;
            8'h98:   op = cpu_pkg::OP_TYA;
            8'h18:   op = cpu_pkg::OP_CLC;
            8'h38:   op = cpu_pkg::OP_SEC;
            8'hB8:   op = cpu_pkg::OP_CLV;
            8'hEA:   op = cpu_pkg::OP_NOP;
            default: op = cpu_pkg::OP_NONE;
        endcase
    end

    // Write-back target per operation
    always_comb begin
        case (op)
            cpu_pkg::OP_LDA, cpu_pkg::OP_ADC, cpu_pkg::OP_SBC,
            cpu_pkg::OP_AND, cpu_pkg::OP_ORA, cpu_pkg::OP_EOR,
            cpu_pkg::OP_ASL, cpu_pkg::OP_LSR, cpu_pkg::OP_ROL,
            cpu_pkg::OP_ROR, cpu_pkg::OP_INC, cpu_pkg::OP_DEC,
            cpu_pkg::OP_TXA, cpu_pkg::OP_TYA:
                dst = cpu_pkg::DST_A;
            cpu_pkg::OP_LDX, cpu_pkg::OP_INX, cpu_pkg::OP_DEX,
            cpu_pkg::OP_TAX:
                dst = cpu_pkg::DST_X;
            cpu_pkg::OP_LDY, cpu_pkg::OP_INY, cpu_pkg::OP_DEY,
            cpu_pkg::OP_TAY:
                dst = cpu_pkg::DST_Y;
            default:
                dst = cpu_pkg::DST_NONE;                // Compares and flag ops
        endcase
    end

    assign legal = (op != cpu_pkg::OP_NONE);

endmodule

// ==== src/alu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Binary arithmetic only. Flags come out in their P positions and
// the caller picks which of them an operation updates.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "cpu_config.svh"

module alu (
    input  cpu_pkg::op_e           op,
    input  logic [`CPU_DATA_W-1:0] a,
    input  logic [`CPU_DATA_W-1:0] b,
    input  logic                   carry_in,
    output logic [`CPU_DATA_W-1:0] result,
    output logic [`CPU_DATA_W-1:0] flags
);

    logic [`CPU_DATA_W:0]   sum;        // Carry out in the top bit
    logic [`CPU_DATA_W-1:0] addend;
    logic                   c_out;
    logic                   v_out;

    // SBC and compares add the complement of b
    assign addend = (op == cpu_pkg::OP_ADC) ? b : ~b;

    always_comb begin
        sum    = '0;
        c_out  = 1'b0;
        v_out  = 1'b0;
        result = '0;
        case (op)
            cpu_pkg::OP_ADC, cpu_pkg::OP_SBC: begin
                sum    = a + addend + carry_in;
                result = sum[`CPU_DATA_W-1:0];
                c_out  = sum[`CPU_DATA_W];
                v_out  = ~(a[7] ^ addend[7]) & (a[7] ^ result[7]);   // Same-sign inputs flip
            end
            cpu_pkg::OP_CMP, cpu_pkg::OP_CPX, cpu_pkg::OP_CPY: begin
                sum    = a + addend + 1'b1;                 // No borrow-in
                result = sum[`CPU_DATA_W-1:0];
                c_out  = sum[`CPU_DATA_W];
            end
            cpu_pkg::OP_AND: result = a & b;
            cpu_pkg::OP_ORA: result = a | b;
            cpu_pkg::OP_EOR: result = a ^ b;
            cpu_pkg::OP_ASL: {c_out, result} = {a, 1'b0};
            cpu_pkg::OP_LSR: {result, c_out} = {1'b0, a};
            cpu_pkg::OP_ROL: {c_out, result} = {a, carry_in};
            cpu_pkg::OP_ROR: {result, c_out} = {carry_in, a};
            cpu_pkg::OP_INC, cpu_pkg::OP_INX, cpu_pkg::OP_INY: result = a + 1'b1;
            cpu_pkg::OP_DEC, cpu_pkg::OP_DEX, cpu_pkg::OP_DEY: result = a - 1'b1;
            cpu_pkg::OP_LDA, cpu_pkg::OP_LDX, cpu_pkg::OP_LDY: result = b;
            cpu_pkg::OP_TAX, cpu_pkg::OP_TAY,
            cpu_pkg::OP_TXA, cpu_pkg::OP_TYA: result = a;
            cpu_pkg::OP_SEC: c_out = 1'b1;
            default: result = '0;                           // CLC and CLV clear
        endcase
    end

    always_comb begin
        flags                 = '0;
        flags[cpu_pkg::FLAG_N] = result[`CPU_DATA_W-1];
        flags[cpu_pkg::FLAG_V] = v_out;
        flags[cpu_pkg::FLAG_Z] = (result == '0);
        flags[cpu_pkg::FLAG_C] = c_out;
    end

endmodule

// ==== src/register_file.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// A, X, Y and P. P bits 5 and 4 always read back as 1 after a write.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "cpu_config.svh"

module register_file (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   wr_a,
    input  logic                   wr_x,
    input  logic                   wr_y,
    input  logic                   wr_p,
    input  logic [`CPU_DATA_W-1:0] wr_data,
    input  logic [`CPU_DATA_W-1:0] wr_p_data,
    output logic [`CPU_DATA_W-1:0] a,
    output logic [`CPU_DATA_W-1:0] x,
    output logic [`CPU_DATA_W-1:0] y,
    output logic [`CPU_DATA_W-1:0] p
);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            a <= '0;
            x <= '0;
            y <= '0;
            p <= `P_RESET;
        end else begin
            if (wr_a) begin
                a <= wr_data;
            end
            if (wr_x) begin
                x <= wr_data;
            end
            if (wr_y) begin
                y <= wr_data;
            end
            if (wr_p) begin
                p <= wr_p_data | 8'h30;         // Unused and B bits stick high
            end
        end
    end

endmodule

// ==== src/exec_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB slave and sequencer. One instruction in flight. An instruction write
// takes two access cycles; every other transfer has no wait states.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "cpu_config.svh"

module exec_ctrl (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic [`APB_DATA_W-1:0] pwdata,
    output logic [`APB_DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic [`CPU_DATA_W-1:0] opcode,
    input  cpu_pkg::op_e           op,
    input  cpu_pkg::dst_e          dst,
    input  logic                   legal,
    output cpu_pkg::op_e           alu_op,
    output logic [`CPU_DATA_W-1:0] alu_a,
    output logic [`CPU_DATA_W-1:0] alu_b,
    output logic                   alu_carry_in,
    input  logic [`CPU_DATA_W-1:0] alu_result,
    input  logic [`CPU_DATA_W-1:0] alu_flags,
    input  logic [`CPU_DATA_W-1:0] a,
    input  logic [`CPU_DATA_W-1:0] x,
    input  logic [`CPU_DATA_W-1:0] y,
    input  logic [`CPU_DATA_W-1:0] p,
    output logic                   wr_a,
    output logic                   wr_x,
    output logic                   wr_y,
    output logic                   wr_p,
    output logic [`CPU_DATA_W-1:0] wr_data,
    output logic [`CPU_DATA_W-1:0] wr_p_data
);

    cpu_pkg::state_e          state;
    cpu_pkg::op_e             op_q;
    cpu_pkg::dst_e            dst_q;
    logic                     legal_q;
    logic [2*`CPU_DATA_W-1:0] instr_q;      // Operand above opcode
    logic                     instr_wr;
    logic                     exec;
    logic [`CPU_DATA_W-1:0]   mask;

    // Flags each operation may change
    function automatic logic [`CPU_DATA_W-1:0] flag_mask(cpu_pkg::op_e o);
        logic [`CPU_DATA_W-1:0] m;
        m = '0;
        case (o)
            cpu_pkg::OP_ADC, cpu_pkg::OP_SBC: begin
                m[cpu_pkg::FLAG_N] = 1'b1;
                m[cpu_pkg::FLAG_V] = 1'b1;
                m[cpu_pkg::FLAG_Z] = 1'b1;
                m[cpu_pkg::FLAG_C] = 1'b1;
            end
            cpu_pkg::OP_CMP, cpu_pkg::OP_CPX, cpu_pkg::OP_CPY,
            cpu_pkg::OP_ASL, cpu_pkg::OP_LSR, cpu_pkg::OP_ROL, cpu_pkg::OP_ROR: begin
                m[cpu_pkg::FLAG_N] = 1'b1;
                m[cpu_pkg::FLAG_Z] = 1'b1;
                m[cpu_pkg::FLAG_C] = 1'b1;
            end
            cpu_pkg::OP_CLC, cpu_pkg::OP_SEC: m[cpu_pkg::FLAG_C] = 1'b1;
            cpu_pkg::OP_CLV:                  m[cpu_pkg::FLAG_V] = 1'b1;
            cpu_pkg::OP_NOP, cpu_pkg::OP_NONE: m = '0;
            default: begin
                m[cpu_pkg::FLAG_N] = 1'b1;              // Loads, moves, logic, inc/dec
                m[cpu_pkg::FLAG_Z] = 1'b1;
            end
        endcase
        return m;
    endfunction

    assign instr_wr = pwrite && (paddr == `ADDR_INSTR);
    assign exec     = (state == cpu_pkg::EXEC);

    // Captured at the setup edge so access cycle one decodes
    always_ff @(posedge i_clk) begin
        if (state == cpu_pkg::IDLE && psel && !penable && instr_wr) begin
            instr_q <= pwdata[2*`CPU_DATA_W-1:0];
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state   <= cpu_pkg::IDLE;
            op_q    <= cpu_pkg::OP_NONE;
            dst_q   <= cpu_pkg::DST_NONE;
            legal_q <= 1'b0;
        end else begin
            case (state)
                cpu_pkg::IDLE: begin
                    if (psel && !penable && instr_wr) begin
                        state <= cpu_pkg::DECODE;
                    end
                end
                cpu_pkg::DECODE: begin
                    op_q    <= op;
                    dst_q   <= dst;
                    legal_q <= legal;
                    state   <= cpu_pkg::EXEC;
                end
                default: state <= cpu_pkg::IDLE;        // Write-back edge
            endcase
        end
    end

    assign opcode       = instr_q[`CPU_DATA_W-1:0];
    assign alu_op       = op_q;
    assign alu_b        = instr_q[2*`CPU_DATA_W-1:`CPU_DATA_W];
    assign alu_carry_in = p[cpu_pkg::FLAG_C];

    always_comb begin
        case (op_q)
            cpu_pkg::OP_CPX, cpu_pkg::OP_INX, cpu_pkg::OP_DEX, cpu_pkg::OP_TXA: alu_a = x;
            cpu_pkg::OP_CPY, cpu_pkg::OP_INY, cpu_pkg::OP_DEY, cpu_pkg::OP_TYA: alu_a = y;
            default: alu_a = a;
        endcase
    end

    assign mask      = flag_mask(op_q);
    assign wr_data   = alu_result;
    assign wr_p_data = (p & ~mask) | (alu_flags & mask);
    assign wr_a      = exec && legal_q && (dst_q == cpu_pkg::DST_A);
    assign wr_x      = exec && legal_q && (dst_q == cpu_pkg::DST_X);
    assign wr_y      = exec && legal_q && (dst_q == cpu_pkg::DST_Y);
    assign wr_p      = exec && legal_q && (mask != '0);

    assign pready  = psel && penable && (exec || !instr_wr);
    assign pslverr = pready && ((pwrite && !instr_wr) || (exec && !legal_q));

    always_comb begin
        case (paddr)
            `ADDR_A: prdata = `APB_DATA_W'(a);
            `ADDR_X: prdata = `APB_DATA_W'(x);
            `ADDR_Y: prdata = `APB_DATA_W'(y);
            `ADDR_P: prdata = `APB_DATA_W'(p);
            default: prdata = '0;                       // Instruction reg reads zero
        endcase
    end

endmodule

// ==== src/cpu_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core top level. The host drives instructions over APB.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_top (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic [`APB_DATA_W-1:0] pwdata,
    output logic [`APB_DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr
);

    logic [`CPU_DATA_W-1:0] opcode;
    cpu_pkg::op_e           op;
    cpu_pkg::dst_e          dst;
    logic                   legal;
    cpu_pkg::op_e           alu_op;
    logic [`CPU_DATA_W-1:0] alu_a;
    logic [`CPU_DATA_W-1:0] alu_b;
    logic                   alu_carry_in;
    logic [`CPU_DATA_W-1:0] alu_result;
    logic [`CPU_DATA_W-1:0] alu_flags;
    logic [`CPU_DATA_W-1:0] a;
    logic [`CPU_DATA_W-1:0] x;
    logic [`CPU_DATA_W-1:0] y;
    logic [`CPU_DATA_W-1:0] p;
    logic                   wr_a;
    logic                   wr_x;
    logic                   wr_y;
    logic                   wr_p;
    logic [`CPU_DATA_W-1:0] wr_data;
    logic [`CPU_DATA_W-1:0] wr_p_data;

    exec_ctrl ctrl_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .opcode       (opcode),
        .op           (op),
        .dst          (dst),
        .legal        (legal),
        .alu_op       (alu_op),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_carry_in (alu_carry_in),
        .alu_result   (alu_result),
        .alu_flags    (alu_flags),
        .a            (a),
        .x            (x),
        .y            (y),
        .p            (p),
        .wr_a         (wr_a),
        .wr_x         (wr_x),
        .wr_y         (wr_y),
        .wr_p         (wr_p),
        .wr_data      (wr_data),
        .wr_p_data    (wr_p_data)
    );

    opcode_decoder decoder_i (
        .opcode (opcode),
        .op     (op),
        .dst    (dst),
        .legal  (legal)
    );

    alu alu_i (
        .op       (alu_op),
        .a        (alu_a),
        .b        (alu_b),
        .carry_in (alu_carry_in),
        .result   (alu_result),
        .flags    (alu_flags)
    );

    register_file regs_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .wr_a      (wr_a),
        .wr_x      (wr_x),
        .wr_y      (wr_y),
        .wr_p      (wr_p),
        .wr_data   (wr_data),
        .wr_p_data (wr_p_data),
        .a         (a),
        .x         (x),
        .y         (y),
        .p         (p)
    );

endmodule

// ==== verification/cpu_properties.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB protocol checks, bound to cpu_top. Inactive during reset.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_properties (
    input logic                   i_clk,
    input logic                   i_rst,
    input logic                   psel,
    input logic                   penable,
    input logic                   pwrite,
    input logic [`APB_ADDR_W-1:0] paddr,
    input logic                   pready,
    input logic                   pslverr
);

    logic instr_access;
    int   failures = 0;                         // Assertion failures so far

    assign instr_access = psel && penable && pwrite && (paddr == `ADDR_INSTR);

    ready_in_access: assert property (@(posedge i_clk) disable iff (i_rst)
        pready |-> (psel && penable))
        else begin
            $error("pready high outside an access cycle");
            failures = failures + 1;
        end

    err_with_ready: assert property (@(posedge i_clk) disable iff (i_rst)
        pslverr |-> pready)
        else begin
            $error("pslverr high without pready");
            failures = failures + 1;
        end

    // First access cycle of an instruction write waits
    instr_wait: assert property (@(posedge i_clk) disable iff (i_rst)
        ($rose(penable) && instr_access) |-> !pready)
        else begin
            $error("instruction write ended in its first access cycle");
            failures = failures + 1;
        end

    instr_done: assert property (@(posedge i_clk) disable iff (i_rst)
        ($rose(penable) && instr_access) |=> pready)
        else begin
            $error("instruction write did not end in its second access cycle");
            failures = failures + 1;
        end

endmodule

// ==== verification/cpu_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compares every completed APB transfer. Read data only checked on reads.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_checker (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`APB_DATA_W-1:0] prdata,
    input  logic                   pready,
    input  logic                   pslverr,
    input  logic [`APB_DATA_W-1:0] exp_rdata,
    input  logic                   exp_err,
    input  logic [8*24-1:0]        test_name,
    output int                     error_count,
    output int                     check_count
);

    int new_errors;

    always @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            error_count <= 0;
            check_count <= 0;
        end else if (psel && penable && pready) begin      // Last access cycle
            new_errors = 0;
            if (!pwrite && prdata !== exp_rdata) begin
                $display("FAIL %0s expected %h actual %h", test_name, exp_rdata, prdata);
                new_errors = new_errors + 1;
            end
            if (pslverr !== exp_err) begin
                $display("FAIL %0s expected pslverr %0d actual pslverr %0d",
                         test_name, exp_err, pslverr);
                new_errors = new_errors + 1;
            end
            error_count <= error_count + new_errors;
            check_count <= check_count + 1;
        end
    end

endmodule

// ==== verification/tb_cpu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top. Run from the project root so the pattern path resolves.
// One APB transfer at a time with an idle cycle between transfers.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "cpu_config.svh"

module tb_cpu;

    localparam string PATTERN_FILE = "verification/cpu_patterns.txt";
    localparam int    NAME_W       = 8*24;      // Up to 24 characters
    localparam int    NEWLINE      = 10;        // ASCII line feed
    localparam int    RESET_CYCLES = 4;

    logic                   i_clk;
    logic                   i_rst;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_ADDR_W-1:0] paddr;
    logic [`APB_DATA_W-1:0] pwdata;
    logic [`APB_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;

    logic [`APB_DATA_W-1:0] exp_rdata;          // Expected values for the checker
    logic                   exp_err;
    logic [NAME_W-1:0]      test_name;
    int                     error_count;
    int                     check_count;

    logic                   kind_q[$];          // 1 for a write
    logic [`APB_ADDR_W-1:0] addr_q[$];
    logic [`APB_DATA_W-1:0] wdata_q[$];
    logic [`APB_DATA_W-1:0] rdata_q[$];
    logic                   err_q[$];
    logic [NAME_W-1:0]      name_q[$];
    logic                   load_failed;
    int                     cycle_cnt = 0;
    int                     cycle_limit = 0;

    cpu_top dut_i (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    cpu_checker checker_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .exp_rdata   (exp_rdata),
        .exp_err     (exp_err),
        .test_name   (test_name),
        .error_count (error_count),
        .check_count (check_count)
    );

    bind cpu_top cpu_properties props_i (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;              // 4 ns period
    end

    function automatic logic is_token(input logic [NAME_W-1:0] tok, input logic [7:0] ch);
        return tok == {{(NAME_W-8){1'b0}}, ch};
    endfunction

    task automatic load_patterns();
        int                     fd;
        int                     r;
        int                     c;
        logic                   done;
        logic [NAME_W-1:0]      tok;
        logic [`APB_ADDR_W-1:0] addr;
        logic [`APB_DATA_W-1:0] wdata;
        logic [`APB_DATA_W-1:0] rdata;
        logic                   err;
        logic [NAME_W-1:0]      name;
        done = 1'b0;
        fd   = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: the pattern file %0s could not be opened", PATTERN_FILE);
            load_failed = 1'b1;
            done        = 1'b1;
        end
        while (!done) begin
            r = $fscanf(fd, "%s", tok);
            if (r != 1) begin
                done = 1'b1;                    // End of file
            end else if (is_token(tok, "#")) begin
                c = 0;
                while (c != NEWLINE && c != -1) begin
                    c = $fgetc(fd);             // Skip the comment line
                end
            end else begin
                r = $fscanf(fd, "%h %h %h %h %s", addr, wdata, rdata, err, name);
                if (r != 5 || !(is_token(tok, "W") || is_token(tok, "R"))) begin
                    $display("ERROR: a pattern line is malformed after %0d good lines",
                             kind_q.size());
                    load_failed = 1'b1;
                    done        = 1'b1;
                end else begin
                    kind_q.push_back(is_token(tok, "W"));
                    addr_q.push_back(addr);
                    wdata_q.push_back(wdata);
                    rdata_q.push_back(rdata);
                    err_q.push_back(err);
                    name_q.push_back(name);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    // Setup cycle, then access cycles until the DUT raises pready
    task automatic run_transfer(
        input logic                   is_write,
        input logic [`APB_ADDR_W-1:0] addr,
        input logic [`APB_DATA_W-1:0] wdata,
        input logic [`APB_DATA_W-1:0] rdata,
        input logic                   err,
        input logic [NAME_W-1:0]      name
    );
        @(posedge i_clk);
        psel      <= 1'b1;
        penable   <= 1'b0;
        pwrite    <= is_write;
        paddr     <= addr;
        pwdata    <= wdata;
        exp_rdata <= rdata;
        exp_err   <= err;
        test_name <= name;
        @(posedge i_clk);
        penable <= 1'b1;
        do begin
            @(posedge i_clk);
        end while (!pready);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    initial begin
        i_rst       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        exp_rdata   = '0;
        exp_err     = 1'b0;
        test_name   = '0;
        load_failed = 1'b0;
        load_patterns();
        cycle_limit = kind_q.size() * `TIMEOUT_PER_TXN + `TIMEOUT_MARGIN;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst <= 1'b0;
        foreach (kind_q[i]) begin
            run_transfer(kind_q[i], addr_q[i], wdata_q[i], rdata_q[i], err_q[i], name_q[i]);
        end
        @(posedge i_clk);
        if (load_failed || kind_q.size() == 0) begin
            $display("ERROR: no complete set of stimulus lines was loaded");
        end
        if (check_count != kind_q.size()) begin
            $display("ERROR: the checker saw a different number of completed transfers");
        end
        $display("Transfers checked: %0d of %0d, errors: %0d, assertion failures: %0d",
                 check_count, kind_q.size(), error_count, dut_i.props_i.failures);
        if (error_count == 0 && dut_i.props_i.failures == 0 && !load_failed
                && kind_q.size() > 0 && check_count == kind_q.size()) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Budget grows with the number of pattern lines
    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("ERROR: timeout after %0d cycles, a transfer never completed", cycle_cnt);
            $display("Finished with errors");
            $finish;
        end
    end

endmodule

// ==== verification/cpu_patterns.txt ====
# kind offset wdata exp_rdata exp_err name; hex fields, wdata is operand then opcode
# exp_rdata is compared on reads only, exp_err on every transfer
R 04 0000 00 0 reset_a
R 08 0000 00 0 reset_x
R 0C 0000 00 0 reset_y
R 10 0000 34 0 reset_p
W 00 00A9 00 0 lda_zero
R 10 0000 36 0 lda_zero_p
W 00 80A9 00 0 lda_neg
R 04 0000 80 0 lda_neg_a
R 10 0000 B4 0 lda_neg_p
W 00 00AA 00 0 tax
R 08 0000 80 0 tax_x
W 00 05A2 00 0 ldx
W 00 008A 00 0 txa
R 04 0000 05 0 txa_a
W 00 F0A0 00 0 ldy_neg
W 00 00A8 00 0 tay
R 0C 0000 05 0 tay_y
W 00 00A0 00 0 ldy_zero
W 00 0098 00 0 tya
R 04 0000 00 0 tya_a
W 00 0018 00 0 clc
W 00 50A9 00 0 lda_50
W 00 5069 00 0 adc_ovf
R 04 0000 A0 0 adc_ovf_a
R 10 0000 F4 0 adc_ovf_p
W 00 00B8 00 0 clv
R 10 0000 B4 0 clv_p
W 00 7069 00 0 adc_carry
R 04 0000 10 0 adc_carry_a
R 10 0000 35 0 adc_carry_p
W 00 0038 00 0 sec
W 00 05E9 00 0 sbc
R 04 0000 0B 0 sbc_a
R 10 0000 35 0 sbc_p
W 00 20E9 00 0 sbc_borrow
R 04 0000 EB 0 sbc_borrow_a
R 10 0000 B4 0 sbc_borrow_p
W 00 EBC9 00 0 cmp_eq
R 04 0000 EB 0 cmp_a
R 10 0000 37 0 cmp_p
W 00 06E0 00 0 cpx_less
R 10 0000 B4 0 cpx_p
W 00 00C0 00 0 cpy_eq
R 10 0000 37 0 cpy_p
W 00 0F29 00 0 and
R 04 0000 0B 0 and_a
W 00 F009 00 0 ora
R 04 0000 FB 0 ora_a
W 00 FB49 00 0 eor
R 04 0000 00 0 eor_a
R 10 0000 37 0 eor_p
W 00 81A9 00 0 lda_81
W 00 000A 00 0 asl
R 04 0000 02 0 asl_a
R 10 0000 35 0 asl_p
W 00 004A 00 0 lsr
W 00 004A 00 0 lsr_zero
R 10 0000 37 0 lsr_zero_p
W 00 006A 00 0 ror
R 04 0000 80 0 ror_a
W 00 002A 00 0 rol
R 10 0000 37 0 rol_p
W 00 003A 00 0 dec_wrap
R 04 0000 FF 0 dec_wrap_a
W 00 001A 00 0 inc_wrap
R 10 0000 37 0 inc_wrap_p
W 00 FFA2 00 0 ldx_ff
W 00 00E8 00 0 inx_wrap
R 08 0000 00 0 inx_x
W 00 00CA 00 0 dex_wrap
R 08 0000 FF 0 dex_x
W 00 0088 00 0 dey_wrap
W 00 00C8 00 0 iny_wrap
R 0C 0000 00 0 iny_y
W 00 00EA 00 0 nop
W 00 0002 00 1 illegal_op
W 04 0055 00 1 write_ro_a
R 04 0000 00 0 err_a
R 08 0000 FF 0 err_x
R 0C 0000 00 0 err_y
R 10 0000 37 0 err_p

// ==== sources.f ====
+incdir+src
src/cpu_pkg.sv
src/opcode_decoder.sv
src/alu.sv
src/register_file.sv
src/exec_ctrl.sv
src/cpu_top.sv
verification/cpu_properties.sv
verification/cpu_checker.sv
verification/tb_cpu.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_cpu
FILELIST   := sources.f
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Finished with no errors
FAIL_MSG   := Finished with errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
